//--- common/vec_ctrl_pkg.sv
// encodings follow the op-v and vsetvli formats; vl is limited to 16 and only 8/16-bit sew step
package vec_ctrl_pkg;

    localparam int XLEN        = 32;
    localparam int VREG_ADDR_W = 5;
    localparam int VL_W        = 5;
    localparam int SEW_W       = 2;
    localparam int CYCLE_W     = 2;
    localparam int IMM_W       = 11;
    localparam int LANES       = 4;

    localparam logic [6:0] V_MAJOR_OP_V = 7'b1010111;

    // funct3 categories
    localparam logic [2:0] V_OPIVV = 3'b000;
    localparam logic [2:0] V_OPMVV = 3'b010;
    localparam logic [2:0] V_OPIVI = 3'b011;
    localparam logic [2:0] V_OPIVX = 3'b100;
    localparam logic [2:0] V_OPCFG = 3'b111;

    // vredsum shares the vadd code and vredmax the vmax code
    localparam logic [5:0] F6_VADD     = 6'b000000;
    localparam logic [5:0] F6_VSUB     = 6'b000010;
    localparam logic [5:0] F6_VMIN     = 6'b000101;
    localparam logic [5:0] F6_VMAX     = 6'b000111;
    localparam logic [5:0] F6_VAND     = 6'b001001;
    localparam logic [5:0] F6_VOR      = 6'b001010;
    localparam logic [5:0] F6_VXOR     = 6'b001011;
    localparam logic [5:0] F6_VMV_X_S  = 6'b010000;
    localparam logic [5:0] F6_VMV_V    = 6'b010111;
    localparam logic [5:0] F6_VSLL     = 6'b100101;
    localparam logic [5:0] F6_VSRL     = 6'b101000;
    localparam logic [5:0] F6_VSRA     = 6'b101001;

    typedef enum logic [2:0] {
        PE_ARITH_ADD,
        PE_ARITH_SUB,
        PE_ARITH_AND,
        PE_ARITH_OR,
        PE_ARITH_XOR,
        PE_ARITH_LSHIFT,
        PE_ARITH_RSHIFT_LOG,
        PE_ARITH_RSHIFT_AR
    } pe_arith_op_t;

    typedef enum logic [1:0] {
        PE_OPERAND_VS1,
        PE_OPERAND_SCALAR,
        PE_OPERAND_IMMEDIATE,
        PE_OPERAND_RIPPLE
    } pe_operand_t;

    typedef enum logic [1:0] {
        PE_OP_MODE_RESULT,
        PE_OP_MODE_PASS_MIN,
        PE_OP_MODE_PASS_MAX
    } pe_output_mode_t;

    typedef enum logic {
        VREG_WB_SRC_ARITH,
        VREG_WB_SRC_SCALAR
    } vreg_wb_src_t;

    typedef enum logic {
        APU_RESULT_SRC_VL,
        APU_RESULT_SRC_VS2_0
    } apu_result_src_t;

    // arithmetic view of an op-v word
    typedef struct packed {
        logic [5:0]             funct6;
        logic                   vm;
        logic [VREG_ADDR_W-1:0] vs2;
        logic [VREG_ADDR_W-1:0] vs1;
        logic [2:0]             funct3;
        logic [VREG_ADDR_W-1:0] vd;
        logic [6:0]             opcode;
    } vec_arith_fmt_t;

    // vsetvli view, zimm holds the vtype request
    typedef struct packed {
        logic                   cfg_msb;
        logic [IMM_W-1:0]       zimm;
        logic [4:0]             rs1;
        logic [2:0]             funct3;
        logic [4:0]             rd;
        logic [6:0]             opcode;
    } vec_cfg_fmt_t;

    typedef union packed {
        vec_arith_fmt_t arith;
        vec_cfg_fmt_t   cfg;
    } vec_instr_u;

endpackage

//--- decoder/vec_op_decode.sv
// purely combinational; every control sits at its idle default unless exec_i is high
module vec_op_decode
    import vec_ctrl_pkg::*;
(
    input  logic             exec_i,
    input  vec_instr_u       instr_i,
    output logic             vec_reg_write_o,
    output vreg_wb_src_t     vd_data_src_o,
    output pe_arith_op_t     pe_op_o,
    output pe_operand_t      operand_select_o,
    output pe_output_mode_t  output_mode_o,
    output apu_result_src_t  apu_result_select_o,
    output logic             csr_write_o,
    output logic             preserve_vl_o,
    output logic             set_vl_max_o,
    output logic [IMM_W-1:0] immediate_o,
    output logic             multi_cycle_o,
    output logic             fix_vd_o
);

    logic is_opi;
    logic is_mvv;
    logic opi_instr;
    logic reduction;
    logic supported;

    // vv, vx and vi forms pick the second operand from funct3
    function automatic pe_operand_t opi_operand(input logic [2:0] f3);
        pe_operand_t sel;
        case (f3)
            V_OPIVX: sel = PE_OPERAND_SCALAR;
            V_OPIVI: sel = PE_OPERAND_IMMEDIATE;
            default: sel = PE_OPERAND_VS1;
        endcase
        return sel;
    endfunction

    assign is_opi = (instr_i.arith.funct3 == V_OPIVV) || (instr_i.arith.funct3 == V_OPIVX) ||
                    (instr_i.arith.funct3 == V_OPIVI);
    assign is_mvv = (instr_i.arith.funct3 == V_OPMVV);

    always_comb
    begin
        vec_reg_write_o     = 1'b0;
        vd_data_src_o       = VREG_WB_SRC_ARITH;
        pe_op_o             = PE_ARITH_ADD;
        operand_select_o    = PE_OPERAND_VS1;
        output_mode_o       = PE_OP_MODE_RESULT;
        apu_result_select_o = APU_RESULT_SRC_VL;
        csr_write_o         = 1'b0;
        preserve_vl_o       = 1'b0;
        set_vl_max_o        = 1'b0;
        immediate_o         = '0;
        multi_cycle_o       = 1'b0;
        fix_vd_o            = 1'b0;
        opi_instr           = 1'b0;
        reduction           = 1'b0;
        supported           = 1'b1;

        if (exec_i)
        begin
            if (instr_i.arith.opcode != V_MAJOR_OP_V)
            begin
                supported = 1'b0;
            end
            else if (instr_i.arith.funct3 == V_OPCFG)
            begin
                // vsetvli, rs1 of zero keeps or maximises vl depending on rd
                csr_write_o = 1'b1;
                immediate_o = instr_i.cfg.zimm;
                if (instr_i.cfg.rs1 == '0)
                begin
                    if (instr_i.cfg.rd == '0)
                        preserve_vl_o = 1'b1;
                    else
                        set_vl_max_o = 1'b1;
                end
            end
            else
            begin
                immediate_o = {{(IMM_W-VREG_ADDR_W){1'b0}}, instr_i.arith.vs1};
                case (instr_i.arith.funct6)
                    F6_VADD:
                    begin
                        pe_op_o   = PE_ARITH_ADD;
                        reduction = is_mvv;
                        opi_instr = !is_mvv;
                    end
                    F6_VMAX:
                    begin
                        pe_op_o       = PE_ARITH_SUB;
                        output_mode_o = PE_OP_MODE_PASS_MAX;
                        reduction     = is_mvv;
                        opi_instr     = !is_mvv;
                    end
                    F6_VSUB:
                    begin
                        pe_op_o   = PE_ARITH_SUB;
                        opi_instr = 1'b1;
                    end
                    F6_VMIN:
                    begin
                        pe_op_o       = PE_ARITH_SUB;
                        output_mode_o = PE_OP_MODE_PASS_MIN;
                        opi_instr     = 1'b1;
                    end
                    F6_VAND:
                    begin
                        pe_op_o   = PE_ARITH_AND;
                        opi_instr = 1'b1;
                    end
                    F6_VOR:
                    begin
                        pe_op_o   = PE_ARITH_OR;
                        opi_instr = 1'b1;
                    end
                    F6_VXOR:
                    begin
                        pe_op_o   = PE_ARITH_XOR;
                        opi_instr = 1'b1;
                    end
                    F6_VSLL:
                    begin
                        pe_op_o   = PE_ARITH_LSHIFT;
                        opi_instr = 1'b1;
                    end
                    F6_VSRL:
                    begin
                        pe_op_o   = PE_ARITH_RSHIFT_LOG;
                        opi_instr = 1'b1;
                    end
                    F6_VSRA:
                    begin
                        pe_op_o   = PE_ARITH_RSHIFT_AR;
                        opi_instr = 1'b1;
                    end
                    F6_VMV_V:
                    begin
                        vd_data_src_o = VREG_WB_SRC_SCALAR;
                        opi_instr     = 1'b1;
                    end
                    F6_VMV_X_S:
                    begin
                        // single cycle read of element 0 back to the core
                        if (is_mvv)
                            apu_result_select_o = APU_RESULT_SRC_VS2_0;
                        else
                            supported = 1'b0;
                    end
                    default:
                        supported = 1'b0;
                endcase

                if (reduction)
                begin
                    // accumulate through the lanes into a single vd element
                    vec_reg_write_o  = 1'b1;
                    multi_cycle_o    = 1'b1;
                    operand_select_o = PE_OPERAND_RIPPLE;
                    fix_vd_o         = 1'b1;
                end
                else if (opi_instr)
                begin
                    if (is_opi)
                    begin
                        vec_reg_write_o  = 1'b1;
                        multi_cycle_o    = 1'b1;
                        operand_select_o = opi_operand(instr_i.arith.funct3);
                    end
                    else
                        supported = 1'b0;
                end
            end
        end
    end

    always_comb
    begin
        if (exec_i)
            assert (supported)
            else $warning("unsupported vector instruction %h", instr_i);
    end

endmodule

//--- decoder/vec_issue_ctrl.sv
// apu request is taken only while idle; vl_i is read live and must hold during execute
module vec_issue_ctrl
    import vec_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               n_reset,
    input  logic               apu_req_i,
    input  logic [XLEN-1:0]    apu_operands_i [3],
    input  logic               multi_cycle_i,
    input  logic [VL_W-1:0]    vl_i,
    output logic               apu_gnt_o,
    output logic               apu_rvalid_o,
    output logic               core_halt_o,
    output logic               exec_o,
    output vec_instr_u         instr_o,
    output logic [XLEN-1:0]    scalar_operand1_o,
    output logic [XLEN-1:0]    scalar_operand2_o,
    output logic [CYCLE_W-1:0] cycle_count_o,
    output logic               last_cycle_o
);

    typedef enum logic {
        ST_IDLE,
        ST_EXEC
    } issue_state_t;

    issue_state_t      state;
    issue_state_t      next_state;
    vec_instr_u        instr_q;
    logic [XLEN-1:0]   operand1_q;
    logic [XLEN-1:0]   operand2_q;
    logic [CYCLE_W-1:0] cycle_count;
    logic [CYCLE_W-1:0] max_cycle;
    logic [VL_W-1:0]   vl_m1;
    logic              accept;

    assign accept = apu_req_i && (state == ST_IDLE);

    // one pass per group of LANES elements
    assign vl_m1     = vl_i - 1'b1;
    assign max_cycle = multi_cycle_i ? CYCLE_W'(vl_m1 >> $clog2(LANES)) : '0;

    assign exec_o       = (state == ST_EXEC);
    assign last_cycle_o = exec_o && (cycle_count == max_cycle);
    assign apu_gnt_o    = (state == ST_IDLE);
    assign apu_rvalid_o = last_cycle_o;
    assign core_halt_o  = exec_o;

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:
            begin
                if (apu_req_i)
                    next_state = ST_EXEC;
            end
            ST_EXEC:
            begin
                if (last_cycle_o)
                    next_state = ST_IDLE;
            end
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_reset)
    begin
        if (!n_reset)
        begin
            state       <= ST_IDLE;
            cycle_count <= '0;
        end
        else
        begin
            state <= next_state;
            if (exec_o)
                cycle_count <= cycle_count + 1'b1;
            else
                cycle_count <= '0;
        end
    end

    // instruction word and scalars held for the whole execute phase
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            instr_q    <= apu_operands_i[0];
            operand1_q <= apu_operands_i[1];
            operand2_q <= apu_operands_i[2];
        end
    end

    assign instr_o           = instr_q;
    assign scalar_operand1_o = operand1_q;
    assign scalar_operand2_o = operand2_q;
    assign cycle_count_o     = cycle_count;

    // execute never counts past the last pass that vl allows
    assert property (@(posedge clk) disable iff (!n_reset)
        exec_o |-> (cycle_count <= max_cycle))
    else $error("execute ran past its last cycle");

endmodule

//--- decoder/vec_reg_sequencer.sv
// address steps cover sew codes 0 and 1 only; other sew codes step as 8-bit
module vec_reg_sequencer
    import vec_ctrl_pkg::*;
(
    input  vec_instr_u                 instr_i,
    input  logic [SEW_W-1:0]           vsew_i,
    input  logic [VL_W-1:0]            vl_i,
    input  logic [CYCLE_W-1:0]         cycle_count_i,
    input  logic                       last_cycle_i,
    input  logic                       multi_cycle_i,
    input  logic                       fix_vd_i,
    input  logic                       reduction_i,
    output logic [VREG_ADDR_W-1:0]     vs1_addr_o,
    output logic [VREG_ADDR_W-1:0]     vs2_addr_o,
    output logic [VREG_ADDR_W-1:0]     vd_addr_o,
    output logic [$clog2(LANES)-1:0]   elements_to_write_o
);

    logic [VREG_ADDR_W-1:0] step;

    // 16-bit elements fill two registers per pass
    always_comb
    begin
        if (vsew_i == 2'd1)
            step = VREG_ADDR_W'({cycle_count_i, 1'b0});
        else
            step = VREG_ADDR_W'(cycle_count_i);
    end

    assign vs1_addr_o = instr_i.arith.vs1 + step;
    assign vs2_addr_o = instr_i.arith.vs2 + step;
    assign vd_addr_o  = fix_vd_i ? instr_i.arith.vd : instr_i.arith.vd + step;

    always_comb
    begin
        elements_to_write_o = '0;
        if (multi_cycle_i && last_cycle_i)
        begin
            // reductions land in a single element
            if (reduction_i)
                elements_to_write_o = 1;
            else
                elements_to_write_o = vl_i[$clog2(LANES)-1:0];
        end
    end

endmodule

//--- rtl/vector_decoder.sv
// one instruction in flight at a time; the result port has no back-pressure
module vector_decoder
    import vec_ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic                     n_reset,
    input  logic                     apu_req_i,
    input  logic [XLEN-1:0]          apu_operands_i [3],
    input  logic [VL_W-1:0]          vl_i,
    input  logic [SEW_W-1:0]         vsew_i,
    output logic                     apu_gnt_o,
    output logic                     apu_rvalid_o,
    output logic                     core_halt_o,
    output logic [XLEN-1:0]          scalar_operand1_o,
    output logic [XLEN-1:0]          scalar_operand2_o,
    output logic [IMM_W-1:0]         immediate_o,
    output logic [VREG_ADDR_W-1:0]   vs1_addr_o,
    output logic [VREG_ADDR_W-1:0]   vs2_addr_o,
    output logic [VREG_ADDR_W-1:0]   vd_addr_o,
    output logic                     csr_write_o,
    output logic                     preserve_vl_o,
    output logic                     set_vl_max_o,
    output logic [$clog2(LANES)-1:0] elements_to_write_o,
    output logic [CYCLE_W-1:0]       cycle_count_o,
    output logic                     vec_reg_write_o,
    output vreg_wb_src_t             vd_data_src_o,
    output pe_arith_op_t             pe_op_o,
    output pe_output_mode_t          output_mode_o,
    output pe_operand_t              operand_select_o,
    output apu_result_src_t          apu_result_select_o
);

    logic       exec;
    vec_instr_u instr;
    logic       multi_cycle;
    logic       fix_vd;
    logic       last_cycle;
    logic       reduction;

    assign reduction = (operand_select_o == PE_OPERAND_RIPPLE);

    vec_issue_ctrl u_vec_issue_ctrl (
        .clk               (clk),
        .n_reset           (n_reset),
        .apu_req_i         (apu_req_i),
        .apu_operands_i    (apu_operands_i),
        .multi_cycle_i     (multi_cycle),
        .vl_i              (vl_i),
        .apu_gnt_o         (apu_gnt_o),
        .apu_rvalid_o      (apu_rvalid_o),
        .core_halt_o       (core_halt_o),
        .exec_o            (exec),
        .instr_o           (instr),
        .scalar_operand1_o (scalar_operand1_o),
        .scalar_operand2_o (scalar_operand2_o),
        .cycle_count_o     (cycle_count_o),
        .last_cycle_o      (last_cycle)
    );

    vec_op_decode u_vec_op_decode (
        .exec_i              (exec),
        .instr_i             (instr),
        .vec_reg_write_o     (vec_reg_write_o),
        .vd_data_src_o       (vd_data_src_o),
        .pe_op_o             (pe_op_o),
        .operand_select_o    (operand_select_o),
        .output_mode_o       (output_mode_o),
        .apu_result_select_o (apu_result_select_o),
        .csr_write_o         (csr_write_o),
        .preserve_vl_o       (preserve_vl_o),
        .set_vl_max_o        (set_vl_max_o),
        .immediate_o         (immediate_o),
        .multi_cycle_o       (multi_cycle),
        .fix_vd_o            (fix_vd)
    );

    vec_reg_sequencer u_vec_reg_sequencer (
        .instr_i             (instr),
        .vsew_i              (vsew_i),
        .vl_i                (vl_i),
        .cycle_count_i       (cycle_count_o),
        .last_cycle_i        (last_cycle),
        .multi_cycle_i       (multi_cycle),
        .fix_vd_i            (fix_vd),
        .reduction_i         (reduction),
        .vs1_addr_o          (vs1_addr_o),
        .vs2_addr_o          (vs2_addr_o),
        .vd_addr_o           (vd_addr_o),
        .elements_to_write_o (elements_to_write_o)
    );

endmodule

//--- test/vector_decoder_tb_tasks.svh
// tasks run inside vector_decoder_tb; outputs are sampled on the falling clock edge
`ifndef VECTOR_DECODER_TB_TASKS_SVH
`define VECTOR_DECODER_TB_TASKS_SVH

task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic check_addr(input string name, input logic [VREG_ADDR_W-1:0] got,
                          input logic [VREG_ADDR_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                           input logic [CNT_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_imm(input string name, input logic [IMM_W-1:0] got,
                         input logic [IMM_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_word(input string name, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_op(input string name, input pe_arith_op_t got, input pe_arith_op_t exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
endtask

task automatic check_operand(input string name, input pe_operand_t got, input pe_operand_t exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
endtask

task automatic check_result_src(input string name, input apu_result_src_t got,
                                input apu_result_src_t exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
endtask

task automatic check_output_mode(input string name, input pe_output_mode_t got,
                                 input pe_output_mode_t exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
endtask

task automatic check_wb_src(input string name, input vreg_wb_src_t got,
                            input vreg_wb_src_t exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
endtask

function automatic logic [4:0] rand_reg();
    return 5'($urandom);
endfunction

// op-v layout: funct6 vm vs2 vs1 funct3 vd opcode
function automatic logic [XLEN-1:0] arith_word(input logic [5:0] f6, input logic [2:0] f3,
                                               input logic [4:0] vs2, input logic [4:0] vs1,
                                               input logic [4:0] vd);
    return {f6, 1'b1, vs2, vs1, f3, vd, V_MAJOR_OP_V};
endfunction

function automatic logic [XLEN-1:0] cfg_word(input logic [IMM_W-1:0] zimm,
                                             input logic [4:0] rs1, input logic [4:0] rd);
    return {1'b0, zimm, rs1, V_OPCFG, rd, V_MAJOR_OP_V};
endfunction

// one pass per group of four elements
function automatic int exec_cycles(input logic multi, input logic [VL_W-1:0] vl_set);
    return multi ? 1 + (int'(vl_set) - 1) / LANES : 1;
endfunction

task automatic issue_instr(input logic [XLEN-1:0] word, input logic [VL_W-1:0] vl_set,
                           input logic [SEW_W-1:0] sew_set);
    int waited;
    waited = 0;
    @(posedge clk);
    #DRIVE_DLY;
    while (!apu_gnt_o && waited < GNT_WAIT)
    begin
        @(posedge clk);
        #DRIVE_DLY;
        waited++;
    end
    if (!apu_gnt_o)
    begin
        errors++;
        $display("no grant from the DUT within %0d cycles at %0t", GNT_WAIT, $time);
    end
    op1_sent        = $urandom;
    op2_sent        = $urandom;
    vl              = vl_set;
    vsew            = sew_set;
    apu_operands[0] = word;
    apu_operands[1] = op1_sent;
    apu_operands[2] = op2_sent;
    apu_req         = 1'b1;
    // edge A takes the request
    @(posedge clk);
    #DRIVE_DLY;
    apu_req = 1'b0;
endtask

// handshake, addresses and element count for execute cycle c of n
task automatic check_cycle(input logic [XLEN-1:0] word, input int c, input int n,
                           input logic multi, input logic red);
    logic [VREG_ADDR_W-1:0] step;
    logic [CNT_W-1:0]       exp_elems;
    @(negedge clk);
    step      = (vsew == 2'd1) ? VREG_ADDR_W'(2 * c) : VREG_ADDR_W'(c);
    exp_elems = '0;
    if (multi && c == n - 1)
        exp_elems = red ? CNT_W'(1) : CNT_W'(vl % LANES);
    check_bit("core_halt_o", core_halt_o, 1'b1);
    check_bit("apu_gnt_o", apu_gnt_o, 1'b0);
    check_bit("apu_rvalid_o", apu_rvalid_o, c == n - 1);
    check_count("cycle_count_o", cycle_count_o, CNT_W'(c));
    check_addr("vs1_addr_o", vs1_addr_o, word[19:15] + step);
    check_addr("vs2_addr_o", vs2_addr_o, word[24:20] + step);
    check_addr("vd_addr_o", vd_addr_o, red ? word[11:7] : word[11:7] + step);
    check_count("elements_to_write_o", elements_to_write_o, exp_elems);
    if (c == 0)
    begin
        check_word("scalar_operand1_o", scalar_operand1_o, op1_sent);
        check_word("scalar_operand2_o", scalar_operand2_o, op2_sent);
    end
endtask

task automatic check_release();
    @(negedge clk);
    check_bit("apu_gnt_o", apu_gnt_o, 1'b1);
    check_bit("apu_rvalid_o", apu_rvalid_o, 1'b0);
    check_bit("core_halt_o", core_halt_o, 1'b0);
    check_bit("vec_reg_write_o", vec_reg_write_o, 1'b0);
endtask

task automatic end_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before)
        $display("test %s: pass", name);
    else
        $display("test %s: %0d failed checks", name, errors - errors_before);
endtask

task automatic test_idle_after_reset();
    int start;
    start = errors;
    @(negedge clk);
    check_bit("apu_gnt_o", apu_gnt_o, 1'b1);
    check_bit("apu_rvalid_o", apu_rvalid_o, 1'b0);
    check_bit("core_halt_o", core_halt_o, 1'b0);
    check_bit("csr_write_o", csr_write_o, 1'b0);
    check_bit("preserve_vl_o", preserve_vl_o, 1'b0);
    check_bit("set_vl_max_o", set_vl_max_o, 1'b0);
    check_bit("vec_reg_write_o", vec_reg_write_o, 1'b0);
    check_count("elements_to_write_o", elements_to_write_o, '0);
    end_test("idle after reset", start);
endtask

task automatic test_vadd_vv();
    logic [XLEN-1:0] word;
    int n;
    int c;
    int start;
    start = errors;
    word  = arith_word(F6_VADD, V_OPIVV, rand_reg(), rand_reg(), rand_reg());
    n     = exec_cycles(1'b1, 5'd10);
    issue_instr(word, 5'd10, 2'd0);
    for (c = 0; c < n; c++)
    begin
        check_cycle(word, c, n, 1'b1, 1'b0);
        check_bit("vec_reg_write_o", vec_reg_write_o, 1'b1);
        check_op("pe_op_o", pe_op_o, PE_ARITH_ADD);
        check_operand("operand_select_o", operand_select_o, PE_OPERAND_VS1);
        check_output_mode("output_mode_o", output_mode_o, PE_OP_MODE_RESULT);
        check_wb_src("vd_data_src_o", vd_data_src_o, VREG_WB_SRC_ARITH);
    end
    check_release();
    end_test("vadd.vv", start);
endtask

task automatic test_vredsum();
    logic [XLEN-1:0] word;
    int n;
    int c;
    int start;
    start = errors;
    word  = arith_word(F6_VADD, V_OPMVV, rand_reg(), rand_reg(), rand_reg());
    n     = exec_cycles(1'b1, 5'd7);
    issue_instr(word, 5'd7, 2'd0);
    for (c = 0; c < n; c++)
    begin
        check_cycle(word, c, n, 1'b1, 1'b1);
        check_bit("vec_reg_write_o", vec_reg_write_o, 1'b1);
        check_operand("operand_select_o", operand_select_o, PE_OPERAND_RIPPLE);
    end
    check_release();
    end_test("vredsum", start);
endtask

task automatic test_vsrl_vi();
    logic [XLEN-1:0] word;
    int n;
    int c;
    int start;
    start = errors;
    word  = arith_word(F6_VSRL, V_OPIVI, rand_reg(), rand_reg(), rand_reg());
    n     = exec_cycles(1'b1, 5'd9);
    issue_instr(word, 5'd9, 2'd1);
    for (c = 0; c < n; c++)
    begin
        check_cycle(word, c, n, 1'b1, 1'b0);
        check_op("pe_op_o", pe_op_o, PE_ARITH_RSHIFT_LOG);
        check_operand("operand_select_o", operand_select_o, PE_OPERAND_IMMEDIATE);
        check_imm("immediate_o", immediate_o, IMM_W'(word[19:15]));
    end
    check_release();
    end_test("vsrl.vi", start);
endtask

task automatic run_vsetvli(input logic [4:0] rs1, input logic [4:0] rd);
    logic [IMM_W-1:0] zimm;
    logic [XLEN-1:0]  word;
    zimm = IMM_W'($urandom);
    word = cfg_word(zimm, rs1, rd);
    issue_instr(word, 5'd4, 2'd0);
    check_cycle(word, 0, 1, 1'b0, 1'b0);
    check_bit("csr_write_o", csr_write_o, 1'b1);
    check_imm("immediate_o", immediate_o, zimm);
    // rs1 of zero keeps vl when rd is zero, otherwise asks for the maximum
    check_bit("preserve_vl_o", preserve_vl_o, rs1 == 5'd0 && rd == 5'd0);
    check_bit("set_vl_max_o", set_vl_max_o, rs1 == 5'd0 && rd != 5'd0);
    check_bit("vec_reg_write_o", vec_reg_write_o, 1'b0);
    check_release();
endtask

task automatic test_vsetvli();
    int start;
    start = errors;
    run_vsetvli(5'd0, 5'd0);
    run_vsetvli(5'd0, 5'($urandom_range(31, 1)));
    run_vsetvli(5'($urandom_range(31, 1)), rand_reg());
    end_test("vsetvli", start);
endtask

task automatic test_single_cycle();
    logic [XLEN-1:0] word;
    int start;
    start = errors;
    word  = arith_word(F6_VMV_X_S, V_OPMVV, rand_reg(), 5'd0, rand_reg());
    issue_instr(word, 5'd8, 2'd0);
    check_cycle(word, 0, 1, 1'b0, 1'b0);
    check_bit("vec_reg_write_o", vec_reg_write_o, 1'b0);
    check_result_src("apu_result_select_o", apu_result_select_o, APU_RESULT_SRC_VS2_0);
    check_release();
    // funct6 with no instruction behind it
    word = arith_word(6'b111111, V_OPIVV, rand_reg(), rand_reg(), rand_reg());
    issue_instr(word, 5'd8, 2'd0);
    check_cycle(word, 0, 1, 1'b0, 1'b0);
    check_bit("vec_reg_write_o", vec_reg_write_o, 1'b0);
    check_bit("csr_write_o", csr_write_o, 1'b0);
    check_result_src("apu_result_select_o", apu_result_select_o, APU_RESULT_SRC_VL);
    check_release();
    end_test("vmv.x.s and unsupported", start);
endtask

`endif

//--- test/vector_decoder_tb.sv
// directed tests with vl in 1..16 and sew codes 0 or 1; the watchdog allows 40 cycles per test
module vector_decoder_tb
    import vec_ctrl_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DLY       = 2;
    localparam int NUM_TESTS       = 6;
    localparam int WATCHDOG_CYCLES = 40;
    localparam int GNT_WAIT        = 10;
    localparam int CNT_W           = $clog2(LANES);

    logic                   clk = 1'b0;
    logic                   n_reset;
    logic                   apu_req;
    logic [XLEN-1:0]        apu_operands [3];
    logic [VL_W-1:0]        vl;
    logic [SEW_W-1:0]       vsew;
    logic                   apu_gnt_o;
    logic                   apu_rvalid_o;
    logic                   core_halt_o;
    logic [XLEN-1:0]        scalar_operand1_o;
    logic [XLEN-1:0]        scalar_operand2_o;
    logic [IMM_W-1:0]       immediate_o;
    logic [VREG_ADDR_W-1:0] vs1_addr_o;
    logic [VREG_ADDR_W-1:0] vs2_addr_o;
    logic [VREG_ADDR_W-1:0] vd_addr_o;
    logic                   csr_write_o;
    logic                   preserve_vl_o;
    logic                   set_vl_max_o;
    logic [CNT_W-1:0]       elements_to_write_o;
    logic [CYCLE_W-1:0]     cycle_count_o;
    logic                   vec_reg_write_o;
    vreg_wb_src_t           vd_data_src_o;
    pe_arith_op_t           pe_op_o;
    pe_output_mode_t        output_mode_o;
    pe_operand_t            operand_select_o;
    apu_result_src_t        apu_result_select_o;

    int              errors;
    int              checks;
    int              tests;
    logic [XLEN-1:0] op1_sent;
    logic [XLEN-1:0] op2_sent;

    always #(CLK_PERIOD / 2) clk = !clk;

    vector_decoder u_vector_decoder (
        .clk                 (clk),
        .n_reset             (n_reset),
        .apu_req_i           (apu_req),
        .apu_operands_i      (apu_operands),
        .vl_i                (vl),
        .vsew_i              (vsew),
        .apu_gnt_o           (apu_gnt_o),
        .apu_rvalid_o        (apu_rvalid_o),
        .core_halt_o         (core_halt_o),
        .scalar_operand1_o   (scalar_operand1_o),
        .scalar_operand2_o   (scalar_operand2_o),
        .immediate_o         (immediate_o),
        .vs1_addr_o          (vs1_addr_o),
        .vs2_addr_o          (vs2_addr_o),
        .vd_addr_o           (vd_addr_o),
        .csr_write_o         (csr_write_o),
        .preserve_vl_o       (preserve_vl_o),
        .set_vl_max_o        (set_vl_max_o),
        .elements_to_write_o (elements_to_write_o),
        .cycle_count_o       (cycle_count_o),
        .vec_reg_write_o     (vec_reg_write_o),
        .vd_data_src_o       (vd_data_src_o),
        .pe_op_o             (pe_op_o),
        .output_mode_o       (output_mode_o),
        .operand_select_o    (operand_select_o),
        .apu_result_select_o (apu_result_select_o)
    );

    `include "vector_decoder_tb_tasks.svh"

    initial
    begin
        void'($urandom(32'he25a59c3));
        errors          = 0;
        checks          = 0;
        tests           = 0;
        n_reset         = 1'b0;
        apu_req         = 1'b0;
        apu_operands[0] = '0;
        apu_operands[1] = '0;
        apu_operands[2] = '0;
        vl              = 5'd1;
        vsew            = '0;
        op1_sent        = '0;
        op2_sent        = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        n_reset = 1'b1;

        test_idle_after_reset();
        test_vadd_vv();
        test_vredsum();
        test_vsrl_vi();
        test_vsetvli();
        test_single_cycle();

        $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // hard stop in case the handshake never completes
    initial
    begin
        #(NUM_TESTS * WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", NUM_TESTS * WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+test
common/vec_ctrl_pkg.sv
decoder/vec_op_decode.sv
decoder/vec_issue_ctrl.sv
decoder/vec_reg_sequencer.sv
rtl/vector_decoder.sv
test/vector_decoder_tb.sv

//--- Makefile
TOP := vector_decoder_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -o vsim
	./obj_dir/vsim > sim.log 2>&1 ; cat sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
